//--- run_sim.sh
#!/usr/bin/env bash
# Build the AXI splitter testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_axi_split \
   -Mdir obj_dir -o sim_axi_split \
   && ./obj_dir/sim_axi_split > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

//--- verification/tb_axi_split.sv
// Directed testbench for the AXI splitter
// Lane slave drivers, a channel monitor, checks and one task per test

`timescale 1ns/1ps
`default_nettype none

module tb_axi_split import split_cfg_pkg::*, axi_bus_pkg::*; ();

   localparam int data_w         = def_data_w;
   localparam int half_w         = def_data_w / 2;
   localparam int out_w          = def_out_addr_w;
   localparam int ax_w           = def_out_addr_w + len_w;
   localparam int timeout_cycles = 200;

   logic clk;
   logic resetn;
   // Upstream side
   logic [def_addr_w-1:0] s_awaddr;
   logic [def_addr_w-1:0] s_araddr;
   len_t s_awlen;
   len_t s_arlen;
   logic s_awvalid, s_awready, s_arvalid, s_arready;
   logic [data_w-1:0] s_wdata;
   logic [data_w-1:0] s_rdata;
   logic s_wlast, s_wvalid, s_wready, s_bvalid, s_bready;
   logic s_rlast, s_rvalid, s_rready;
   // Lane side with lane 0 and lane 1 side by side
   logic [out_w-1:0] m0_awaddr, m1_awaddr, m0_araddr, m1_araddr;
   len_t m0_awlen, m1_awlen, m0_arlen, m1_arlen;
   logic m0_awvalid, m1_awvalid, m0_awready, m1_awready;
   logic m0_arvalid, m1_arvalid, m0_arready, m1_arready;
   logic [half_w-1:0] m0_wdata, m1_wdata, m0_rdata, m1_rdata;
   logic m0_wlast, m1_wlast, m0_wvalid, m1_wvalid, m0_wready, m1_wready;
   logic m0_bvalid, m1_bvalid, m0_bready, m1_bready;
   logic m0_rlast, m1_rlast, m0_rvalid, m1_rvalid, m0_rready, m1_rready;

   // Transfers seen by the monitor in arrival order
   logic [ax_w-1:0]   q_aw0[$];
   logic [ax_w-1:0]   q_aw1[$];
   logic [ax_w-1:0]   q_ar0[$];
   logic [ax_w-1:0]   q_ar1[$];
   logic [half_w:0]   q_w0[$];
   logic [half_w:0]   q_w1[$];
   logic [data_w:0]   q_r[$];
   int                b_count;
   int                errors;
   int                checks;
   logic [31:0]       rng_state = 32'hfea70ea1;

   axi_split_top u_axi_split_top (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //========================================
   // Monitor
   //========================================

   // Valid and ready are stable at the falling edge
   // The transfer itself happens at the next rise
   always @(negedge clk) begin
      if (resetn) begin
         if (m0_awvalid && m0_awready) q_aw0.push_back({m0_awaddr, m0_awlen});
         if (m1_awvalid && m1_awready) q_aw1.push_back({m1_awaddr, m1_awlen});
         if (m0_arvalid && m0_arready) q_ar0.push_back({m0_araddr, m0_arlen});
         if (m1_arvalid && m1_arready) q_ar1.push_back({m1_araddr, m1_arlen});
         if (m0_wvalid && m0_wready) q_w0.push_back({m0_wdata, m0_wlast});
         if (m1_wvalid && m1_wready) q_w1.push_back({m1_wdata, m1_wlast});
         if (s_rvalid && s_rready) q_r.push_back({s_rlast, s_rdata});
         if (s_bvalid && s_bready) b_count++;
      end
   end

   //========================================
   // Helpers
   //========================================

   // LCG step
   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Half the address plus the base, cut to lane width
   function automatic logic [out_w-1:0] lane_addr(logic [31:0] addr, logic [31:0] base);
      logic [31:0] sum;
      sum = (addr >> 1) + base;
      return sum[out_w-1:0];
   endfunction

   task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // One address FIFO item against the rule
   task automatic check_addr_item(string pfx, logic [ax_w-1:0] item, logic [31:0] addr,
                                  len_t len, logic [31:0] base);
      check_val({pfx, "addr"}, 64'(item[ax_w-1:len_w]), 64'(lane_addr(addr, base)));
      check_val({pfx, "len"}, 64'(item[len_w-1:0]), 64'(len));
   endtask

   // Selectors in order aw0 aw1 w0 w1 ar0 ar1 r
   // Any other selector gives the B count
   function automatic int item_count(int sel);
      int n;
      case (sel)
         0: n = q_aw0.size();
         1: n = q_aw1.size();
         2: n = q_w0.size();
         3: n = q_w1.size();
         4: n = q_ar0.size();
         5: n = q_ar1.size();
         6: n = q_r.size();
         default: n = b_count;
      endcase
      return n;
   endfunction

   // Selectors in order upstream aw w ar then lane b0 b1 r0 r1
   function automatic logic ready_of(int sel);
      logic r;
      case (sel)
         0: r = s_awready;
         1: r = s_wready;
         2: r = s_arready;
         3: r = m0_bready;
         4: r = m1_bready;
         5: r = m0_rready;
         default: r = m1_rready;
      endcase
      return r;
   endfunction

   task automatic wait_items(int sel, int n, string what);
      int t;
      for (t = 0; t < timeout_cycles; t++) begin
         if (item_count(sel) >= n) break;
         @(posedge clk);
      end
      if (item_count(sel) < n) begin
         errors++;
         $display("timeout: only %0d of %0d transfers seen on %s", item_count(sel), n, what);
      end
   endtask

   // Returns on the rising edge that completes the handshake
   task automatic wait_ready(int sel, string what);
      int t;
      for (t = 0; t < timeout_cycles; t++) begin
         @(negedge clk);
         if (ready_of(sel)) break;
      end
      if (t == timeout_cycles) begin
         errors++;
         $display("timeout: %s never became ready", what);
      end
      @(posedge clk);
   endtask

   task automatic send_aw(logic [31:0] addr, len_t len);
      @(posedge clk);
      s_awaddr  <= addr;
      s_awlen   <= len;
      s_awvalid <= 1'b1;
      wait_ready(0, "upstream AW");
      s_awvalid <= 1'b0;
   endtask

   task automatic send_ar(logic [31:0] addr, len_t len);
      @(posedge clk);
      s_araddr  <= addr;
      s_arlen   <= len;
      s_arvalid <= 1'b1;
      wait_ready(2, "upstream AR");
      s_arvalid <= 1'b0;
   endtask

   task automatic send_w(logic [data_w-1:0] data, logic last);
      @(posedge clk);
      s_wdata  <= data;
      s_wlast  <= last;
      s_wvalid <= 1'b1;
      wait_ready(1, "upstream W");
      s_wvalid <= 1'b0;
   endtask

   // Lane slave write response
   task automatic lane_b(int lane);
      @(posedge clk);
      if (lane == 0) m0_bvalid <= 1'b1;
      else m1_bvalid <= 1'b1;
      wait_ready(lane == 0 ? 3 : 4, "lane B");
      if (lane == 0) m0_bvalid <= 1'b0;
      else m1_bvalid <= 1'b0;
   endtask

   // Lane slave read beat
   task automatic lane_r(int lane, logic [half_w-1:0] data, logic last);
      @(posedge clk);
      if (lane == 0) begin
         m0_rdata  <= data;
         m0_rlast  <= last;
         m0_rvalid <= 1'b1;
      end else begin
         m1_rdata  <= data;
         m1_rlast  <= last;
         m1_rvalid <= 1'b1;
      end
      wait_ready(lane == 0 ? 5 : 6, "lane R");
      if (lane == 0) m0_rvalid <= 1'b0;
      else m1_rvalid <= 1'b0;
   endtask

   task automatic clear_queues();
      q_aw0.delete();
      q_aw1.delete();
      q_ar0.delete();
      q_ar1.delete();
      q_w0.delete();
      q_w1.delete();
      q_r.delete();
      b_count = 0;
   endtask

   //========================================
   // Tests
   //========================================

   task automatic split_write_addresses();
      logic [31:0] addr [6];
      len_t        len [6];
      clear_queues();
      for (int i = 0; i < 6; i++) begin
         addr[i] = next_rand();
         len[i]  = len_t'(next_rand());
         send_aw(addr[i], len[i]);
      end
      wait_items(0, 6, "lane 0 AW");
      wait_items(1, 6, "lane 1 AW");
      for (int i = 0; i < 6; i++) begin
         check_addr_item("m0_aw", q_aw0[i], addr[i], len[i], def_base0);
         check_addr_item("m1_aw", q_aw1[i], addr[i], len[i], def_base1);
      end
   endtask

   task automatic split_write_data();
      logic [data_w-1:0] data [4];
      logic [half_w:0]   item;
      clear_queues();
      for (int i = 0; i < 4; i++) begin
         data[i] = {next_rand(), next_rand()};
         send_w(data[i], i == 3);
      end
      wait_items(2, 4, "lane 0 W");
      wait_items(3, 4, "lane 1 W");
      for (int i = 0; i < 4; i++) begin
         item = q_w0[i];
         check_val("m0_wdata", 64'(item[half_w:1]), 64'(data[i][half_w-1:0]));
         check_val("m0_wlast", 64'(item[0]), 64'(i == 3));
         item = q_w1[i];
         check_val("m1_wdata", 64'(item[half_w:1]), 64'(data[i][data_w-1:half_w]));
         check_val("m1_wlast", 64'(item[0]), 64'(i == 3));
      end
   endtask

   task automatic merge_write_responses();
      clear_queues();
      lane_b(0);
      lane_b(0);
      // No upstream response may appear while lane 1 has none
      for (int i = 0; i < 20; i++) begin
         @(negedge clk);
         check_val("s_bvalid", 64'(s_bvalid), 64'(0));
      end
      lane_b(1);
      wait_items(7, 1, "upstream B");
      repeat (10) @(posedge clk);
      check_val("upstream B count", 64'(b_count), 64'(1));
      lane_b(1);
      wait_items(7, 2, "upstream B");
      repeat (10) @(posedge clk);
      check_val("upstream B count", 64'(b_count), 64'(2));
   endtask

   task automatic split_and_merge_reads();
      logic [31:0]       addr [3];
      len_t              len [3];
      logic [half_w-1:0] d0 [4];
      logic [half_w-1:0] d1 [4];
      logic [data_w:0]   beat;
      clear_queues();
      for (int i = 0; i < 3; i++) begin
         addr[i] = next_rand();
         len[i]  = len_t'(next_rand());
         send_ar(addr[i], len[i]);
      end
      wait_items(4, 3, "lane 0 AR");
      wait_items(5, 3, "lane 1 AR");
      for (int i = 0; i < 3; i++) begin
         check_addr_item("m0_ar", q_ar0[i], addr[i], len[i], def_base0);
         check_addr_item("m1_ar", q_ar1[i], addr[i], len[i], def_base1);
      end
      // Lane 0 beats go back to back and lane 1 follows later with growing gaps
      for (int i = 0; i < 4; i++) begin
         d0[i] = next_rand();
         d1[i] = next_rand();
         lane_r(0, d0[i], i == 3);
      end
      @(negedge clk);
      check_val("s_rvalid", 64'(s_rvalid), 64'(0));
      // Lane 1 marks last on its first beat and that flag must not reach upstream
      for (int i = 0; i < 4; i++) begin
         repeat (i + 2) @(posedge clk);
         lane_r(1, d1[i], i == 0);
      end
      wait_items(6, 4, "upstream R");
      for (int i = 0; i < 4; i++) begin
         beat = q_r[i];
         check_val("s_rdata", beat[data_w-1:0], {d1[i], d0[i]});
         check_val("s_rlast", 64'(beat[data_w]), 64'(i == 3));
      end
   endtask

   task automatic stall_one_lane();
      logic [31:0] addr [def_ax_depth+1];
      len_t        len [def_ax_depth+1];
      clear_queues();
      @(posedge clk);
      m1_awready <= 1'b0;
      for (int i = 0; i < def_ax_depth; i++) begin
         addr[i] = next_rand();
         len[i]  = len_t'(next_rand());
         send_aw(addr[i], len[i]);
      end
      addr[def_ax_depth] = next_rand();
      len[def_ax_depth]  = len_t'(next_rand());
      @(posedge clk);
      s_awaddr  <= addr[def_ax_depth];
      s_awlen   <= len[def_ax_depth];
      s_awvalid <= 1'b1;
      // Lane 1 FIFO is full now
      for (int i = 0; i < 20; i++) begin
         @(negedge clk);
         check_val("s_awready", 64'(s_awready), 64'(0));
      end
      // Lane 0 drains freely so it shows how many addresses went in
      check_val("lane 0 AW count", 64'(q_aw0.size()), 64'(def_ax_depth));
      @(posedge clk);
      m1_awready <= 1'b1;
      wait_ready(0, "upstream AW after release");
      s_awvalid <= 1'b0;
      wait_items(0, def_ax_depth + 1, "lane 0 AW");
      wait_items(1, def_ax_depth + 1, "lane 1 AW");
      for (int i = 0; i <= def_ax_depth; i++) begin
         check_addr_item("m0_aw", q_aw0[i], addr[i], len[i], def_base0);
         check_addr_item("m1_aw", q_aw1[i], addr[i], len[i], def_base1);
      end
   endtask

   //========================================
   // Main sequence
   //========================================

   initial begin
      errors = 0;
      checks = 0;
      b_count = 0;
      resetn <= 1'b0;
      s_awaddr <= '0;
      s_awlen <= '0;
      s_awvalid <= 1'b0;
      s_wdata <= '0;
      s_wlast <= 1'b0;
      s_wvalid <= 1'b0;
      s_bready <= 1'b1;
      s_araddr <= '0;
      s_arlen <= '0;
      s_arvalid <= 1'b0;
      s_rready <= 1'b1;
      m0_awready <= 1'b1;
      m1_awready <= 1'b1;
      m0_wready <= 1'b1;
      m1_wready <= 1'b1;
      m0_arready <= 1'b1;
      m1_arready <= 1'b1;
      m0_bvalid <= 1'b0;
      m1_bvalid <= 1'b0;
      m0_rdata <= '0;
      m1_rdata <= '0;
      m0_rlast <= 1'b0;
      m1_rlast <= 1'b0;
      m0_rvalid <= 1'b0;
      m1_rvalid <= 1'b0;
      // Upstream readies stay low during the five reset edges
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_val("s_awready in reset", 64'(s_awready), 64'(0));
      check_val("s_wready in reset", 64'(s_wready), 64'(0));
      check_val("s_arready in reset", 64'(s_arready), 64'(0));
      @(posedge clk);
      resetn <= 1'b1;
      @(negedge clk);
      check_val("valids after reset",
                64'({s_bvalid, s_rvalid, m0_awvalid, m1_awvalid, m0_wvalid, m1_wvalid,
                     m0_arvalid, m1_arvalid}), 64'(0));
      split_write_addresses();
      split_write_data();
      merge_write_responses();
      split_and_merge_reads();
      stall_one_lane();
      repeat (5) @(posedge clk);
      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/axi_bus_pkg.sv
// AXI field widths shared by the bus-facing modules
// Burst length width and the burst length type

`default_nettype none

package axi_bus_pkg;

   //======================================
   // Burst length
   //======================================

   // AXI4 burst length field, beats minus one
   localparam int len_w = 8;

   // Length as carried through the address FIFOs
   typedef logic [len_w-1:0] len_t;

   // Other AXI fields (ID, burst, cache, QoS, prot, strobes)
   // are not carried by this splitter

endpackage

`default_nettype wire

//--- verilog/axi_split_top.sv
// AXI4 splitter top level
// One wide slave port into two half-width master lanes

`timescale 1ns/1ps
`default_nettype none

module axi_split_top import split_cfg_pkg::*, axi_bus_pkg::*; #(
   parameter int data_w     = def_data_w,
   parameter int addr_w     = def_addr_w,
   parameter int out_addr_w = def_out_addr_w,
   parameter int ax_depth   = def_ax_depth,
   parameter int data_depth = def_data_depth,
   parameter int credit_w   = def_credit_w
) (
   input  logic                  clk,
   input  logic                  resetn,
   // Upstream write
   input  logic [addr_w-1:0]     s_awaddr,
   input  len_t                  s_awlen,
   input  logic                  s_awvalid,
   output logic                  s_awready,
   input  logic [data_w-1:0]     s_wdata,
   input  logic                  s_wlast,
   input  logic                  s_wvalid,
   output logic                  s_wready,
   output logic                  s_bvalid,
   input  logic                  s_bready,
   // Upstream read
   input  logic [addr_w-1:0]     s_araddr,
   input  len_t                  s_arlen,
   input  logic                  s_arvalid,
   output logic                  s_arready,
   output logic [data_w-1:0]     s_rdata,
   output logic                  s_rlast,
   output logic                  s_rvalid,
   input  logic                  s_rready,
   // Lane 0
   output logic [out_addr_w-1:0] m0_awaddr,
   output len_t                  m0_awlen,
   output logic                  m0_awvalid,
   input  logic                  m0_awready,
   output logic [data_w/2-1:0]   m0_wdata,
   output logic                  m0_wlast,
   output logic                  m0_wvalid,
   input  logic                  m0_wready,
   input  logic                  m0_bvalid,
   output logic                  m0_bready,
   output logic [out_addr_w-1:0] m0_araddr,
   output len_t                  m0_arlen,
   output logic                  m0_arvalid,
   input  logic                  m0_arready,
   input  logic [data_w/2-1:0]   m0_rdata,
   input  logic                  m0_rlast,
   input  logic                  m0_rvalid,
   output logic                  m0_rready,
   // Lane 1
   output logic [out_addr_w-1:0] m1_awaddr,
   output len_t                  m1_awlen,
   output logic                  m1_awvalid,
   input  logic                  m1_awready,
   output logic [data_w/2-1:0]   m1_wdata,
   output logic                  m1_wlast,
   output logic                  m1_wvalid,
   input  logic                  m1_wready,
   input  logic                  m1_bvalid,
   output logic                  m1_bready,
   output logic [out_addr_w-1:0] m1_araddr,
   output len_t                  m1_arlen,
   output logic                  m1_arvalid,
   input  logic                  m1_arready,
   input  logic [data_w/2-1:0]   m1_rdata,
   input  logic                  m1_rlast,
   input  logic                  m1_rvalid,
   output logic                  m1_rready
);

   localparam int half_w = data_w / 2;

   lane_ctrl_if lane0_if ();
   lane_ctrl_if lane1_if ();

   //======================================
   // Handshake join and B credits
   //======================================

   split_join_ctrl #(.credit_w(credit_w)) u_ctrl (
      .clk(clk), .resetn(resetn),
      .s_awvalid(s_awvalid), .s_wvalid(s_wvalid), .s_arvalid(s_arvalid),
      .s_rready(s_rready), .s_bready(s_bready),
      .s_awready(s_awready), .s_wready(s_wready), .s_arready(s_arready),
      .s_rvalid(s_rvalid), .s_bvalid(s_bvalid),
      .lane0(lane0_if), .lane1(lane1_if)
   );

   //======================================
   // Lanes
   //======================================

   // Lane 0 takes the low half and supplies RLAST
   split_lane #(
      .data_w(data_w), .addr_w(addr_w), .out_addr_w(out_addr_w),
      .ax_depth(ax_depth), .data_depth(data_depth), .lane_base(def_base0)
   ) u_lane0 (
      .clk(clk), .resetn(resetn),
      .s_awaddr(s_awaddr), .s_awlen(s_awlen), .s_araddr(s_araddr), .s_arlen(s_arlen),
      .s_wdata_half(s_wdata[half_w-1:0]), .s_wlast(s_wlast), .s_bready(s_bready),
      .r_data(s_rdata[half_w-1:0]), .r_last(s_rlast),
      .ctl(lane0_if),
      .m_awaddr(m0_awaddr), .m_awlen(m0_awlen),
      .m_awvalid(m0_awvalid), .m_awready(m0_awready),
      .m_wdata(m0_wdata), .m_wlast(m0_wlast), .m_wvalid(m0_wvalid), .m_wready(m0_wready),
      .m_bvalid(m0_bvalid), .m_bready(m0_bready),
      .m_araddr(m0_araddr), .m_arlen(m0_arlen),
      .m_arvalid(m0_arvalid), .m_arready(m0_arready),
      .m_rdata(m0_rdata), .m_rlast(m0_rlast), .m_rvalid(m0_rvalid), .m_rready(m0_rready)
   );

   // Lane 1 takes the high half, its RLAST is not used upstream
   split_lane #(
      .data_w(data_w), .addr_w(addr_w), .out_addr_w(out_addr_w),
      .ax_depth(ax_depth), .data_depth(data_depth), .lane_base(def_base1)
   ) u_lane1 (
      .clk(clk), .resetn(resetn),
      .s_awaddr(s_awaddr), .s_awlen(s_awlen), .s_araddr(s_araddr), .s_arlen(s_arlen),
      .s_wdata_half(s_wdata[data_w-1:half_w]), .s_wlast(s_wlast), .s_bready(s_bready),
      .r_data(s_rdata[data_w-1:half_w]), .r_last(),
      .ctl(lane1_if),
      .m_awaddr(m1_awaddr), .m_awlen(m1_awlen),
      .m_awvalid(m1_awvalid), .m_awready(m1_awready),
      .m_wdata(m1_wdata), .m_wlast(m1_wlast), .m_wvalid(m1_wvalid), .m_wready(m1_wready),
      .m_bvalid(m1_bvalid), .m_bready(m1_bready),
      .m_araddr(m1_araddr), .m_arlen(m1_arlen),
      .m_arvalid(m1_arvalid), .m_arready(m1_arready),
      .m_rdata(m1_rdata), .m_rlast(m1_rlast), .m_rvalid(m1_rvalid), .m_rready(m1_rready)
   );

endmodule

`default_nettype wire

//--- verilog/lane_ctrl_if.sv
// Control link between the join logic and one output lane
// Readies and valids from the lane, joined pushes and pops to it

`timescale 1ns/1ps
`default_nettype none

interface lane_ctrl_if;

   // Lane input FIFOs not full
   logic aw_ready;
   logic w_ready;
   logic ar_ready;

   // Joined upstream handshakes, push into both lanes at once
   logic aw_push;
   logic w_push;
   logic ar_push;

   // Lane R FIFO holds a beat
   logic r_valid;
   // Joined upstream R handshake
   logic r_pop;

   // Lane accepted a write response this cycle
   logic b_done;

   // Join side
   modport ctrl (
      input  aw_ready, w_ready, ar_ready, r_valid, b_done,
      output aw_push, w_push, ar_push, r_pop
   );

   // Lane side
   modport lane (
      output aw_ready, w_ready, ar_ready, r_valid, b_done,
      input  aw_push, w_push, ar_push, r_pop
   );

endinterface

`default_nettype wire

//--- verilog/split_cfg_pkg.sv
// Default configuration of the AXI splitter
// Data and address widths, FIFO depths, lane base addresses

`default_nettype none

package split_cfg_pkg;

   // Upstream data width in bits
   localparam int def_data_w     = 64;
   // Upstream address width
   localparam int def_addr_w     = 32;
   // Lane address width
   localparam int def_out_addr_w = 28;

   // FIFO depths in entries
   localparam int def_ax_depth   = 4;
   localparam int def_data_depth = 16;

   // Base address added after the divide by two
   localparam logic [31:0] def_base0 = 32'h0000_0000;
   localparam logic [31:0] def_base1 = 32'h0800_0000;

   // Width of each write-response credit counter
   localparam int def_credit_w   = 8;

endpackage

`default_nettype wire

//--- verilog/split_join_ctrl.sv
// Joins the upstream handshakes across both lanes
// Write-response credit counters, one per lane

`timescale 1ns/1ps
`default_nettype none

module split_join_ctrl import split_cfg_pkg::*; #(
   parameter int credit_w = def_credit_w
) (
   input  logic      clk,
   input  logic      resetn,
   input  logic      s_awvalid,
   input  logic      s_wvalid,
   input  logic      s_arvalid,
   input  logic      s_rready,
   input  logic      s_bready,
   output logic      s_awready,
   output logic      s_wready,
   output logic      s_arready,
   output logic      s_rvalid,
   output logic      s_bvalid,
   lane_ctrl_if.ctrl lane0,
   lane_ctrl_if.ctrl lane1
);

   logic [credit_w-1:0] credit [2];
   logic [1:0]          b_add;
   logic                b_take;

   //======================================
   // AW, W and AR joins
   //======================================

   // Ready only when both lanes have room, and never in reset
   assign s_awready = resetn & lane0.aw_ready & lane1.aw_ready;
   assign s_wready  = resetn & lane0.w_ready  & lane1.w_ready;
   assign s_arready = resetn & lane0.ar_ready & lane1.ar_ready;

   // One handshake pushes into both lanes
   assign lane0.aw_push = s_awvalid & s_awready;
   assign lane1.aw_push = s_awvalid & s_awready;
   assign lane0.w_push  = s_wvalid & s_wready;
   assign lane1.w_push  = s_wvalid & s_wready;
   assign lane0.ar_push = s_arvalid & s_arready;
   assign lane1.ar_push = s_arvalid & s_arready;

   //======================================
   // R join
   //======================================

   // A full beat needs both halves
   assign s_rvalid    = lane0.r_valid & lane1.r_valid;
   assign lane0.r_pop = s_rvalid & s_rready;
   assign lane1.r_pop = s_rvalid & s_rready;

   //======================================
   // B credits
   //======================================

   assign b_add  = {lane1.b_done, lane0.b_done};
   assign b_take = s_bvalid & s_bready;

   // One upstream response per pair of lane responses
   assign s_bvalid = (credit[0] != '0) & (credit[1] != '0);

   // Add on a lane response, take on an upstream response
   always_ff @(posedge clk) begin
      if (!resetn) begin
         credit[0] <= '0;
         credit[1] <= '0;
      end else begin
         for (int i = 0; i < 2; i++) begin
            if (b_add[i] && !b_take) begin
               credit[i] <= credit[i] + credit_w'(1);
            end else if (!b_add[i] && b_take) begin
               credit[i] <= credit[i] - credit_w'(1);
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/split_lane.sv
// One half-width output lane of the AXI splitter
// Address remap and the AW, W, AR and R channel FIFOs

`timescale 1ns/1ps
`default_nettype none

module split_lane import split_cfg_pkg::*, axi_bus_pkg::*; #(
   parameter int          data_w     = def_data_w,
   parameter int          addr_w     = def_addr_w,
   parameter int          out_addr_w = def_out_addr_w,
   parameter int          ax_depth   = def_ax_depth,
   parameter int          data_depth = def_data_depth,
   parameter logic [31:0] lane_base  = def_base0
) (
   input  logic                    clk,
   input  logic                    resetn,
   // Upstream side, already qualified by the join logic
   input  logic [addr_w-1:0]       s_awaddr,
   input  len_t                    s_awlen,
   input  logic [addr_w-1:0]       s_araddr,
   input  len_t                    s_arlen,
   input  logic [data_w/2-1:0]     s_wdata_half,
   input  logic                    s_wlast,
   input  logic                    s_bready,
   output logic [data_w/2-1:0]     r_data,
   output logic                    r_last,
   lane_ctrl_if.lane               ctl,
   // Lane AXI master
   output logic [out_addr_w-1:0]   m_awaddr,
   output len_t                    m_awlen,
   output logic                    m_awvalid,
   input  logic                    m_awready,
   output logic [data_w/2-1:0]     m_wdata,
   output logic                    m_wlast,
   output logic                    m_wvalid,
   input  logic                    m_wready,
   input  logic                    m_bvalid,
   output logic                    m_bready,
   output logic [out_addr_w-1:0]   m_araddr,
   output len_t                    m_arlen,
   output logic                    m_arvalid,
   input  logic                    m_arready,
   input  logic [data_w/2-1:0]     m_rdata,
   input  logic                    m_rlast,
   input  logic                    m_rvalid,
   output logic                    m_rready
);

   localparam int half_w = data_w / 2;
   // Address plus burst length
   localparam int ax_w   = out_addr_w + len_w;

   logic [out_addr_w-1:0] aw_remap;
   logic [out_addr_w-1:0] ar_remap;

   //======================================
   // Address remap
   //======================================

   // Half the upstream address plus this lane's base, cut to lane width
   assign aw_remap = out_addr_w'((s_awaddr >> 1) + addr_w'(lane_base));
   assign ar_remap = out_addr_w'((s_araddr >> 1) + addr_w'(lane_base));

   //======================================
   // Channel FIFOs
   //======================================

   // Write address
   sync_fifo #(.width(ax_w), .depth(ax_depth)) u_aw_fifo (
      .clk(clk), .resetn(resetn),
      .in_data({aw_remap, s_awlen}), .in_valid(ctl.aw_push), .in_ready(ctl.aw_ready),
      .out_data({m_awaddr, m_awlen}), .out_valid(m_awvalid), .out_ready(m_awready)
   );

   // Write data, this lane's half of each beat
   sync_fifo #(.width(half_w + 1), .depth(data_depth)) u_w_fifo (
      .clk(clk), .resetn(resetn),
      .in_data({s_wdata_half, s_wlast}), .in_valid(ctl.w_push), .in_ready(ctl.w_ready),
      .out_data({m_wdata, m_wlast}), .out_valid(m_wvalid), .out_ready(m_wready)
   );

   // Read address
   sync_fifo #(.width(ax_w), .depth(ax_depth)) u_ar_fifo (
      .clk(clk), .resetn(resetn),
      .in_data({ar_remap, s_arlen}), .in_valid(ctl.ar_push), .in_ready(ctl.ar_ready),
      .out_data({m_araddr, m_arlen}), .out_valid(m_arvalid), .out_ready(m_arready)
   );

   // Read data waits here until the other lane has its beat too
   sync_fifo #(.width(half_w + 1), .depth(data_depth)) u_r_fifo (
      .clk(clk), .resetn(resetn),
      .in_data({m_rdata, m_rlast}), .in_valid(m_rvalid), .in_ready(m_rready),
      .out_data({r_data, r_last}), .out_valid(ctl.r_valid), .out_ready(ctl.r_pop)
   );

   //======================================
   // Write response
   //======================================

   // Responses are counted upstream, so accept whenever upstream could
   assign m_bready   = s_bready & resetn;
   assign ctl.b_done = m_bvalid & m_bready;

endmodule

`default_nettype wire

//--- verilog/sync_fifo.sv
// Synchronous FIFO with first-word-fall-through output
// Valid/ready on both sides, circular buffer with occupancy count

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter int width = 8,
   parameter int depth = 4
) (
   input  logic             clk,
   input  logic             resetn,
   input  logic [width-1:0] in_data,
   input  logic             in_valid,
   output logic             in_ready,
   output logic [width-1:0] out_data,
   output logic             out_valid,
   input  logic             out_ready
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   logic [width-1:0] mem [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             push;
   logic             pop;

   // Full blocks push, empty blocks pop
   assign in_ready  = (count != cnt_w'(depth));
   assign out_valid = (count != '0);
   assign push      = in_valid & in_ready;
   assign pop       = out_valid & out_ready;

   // Head entry is always on the output
   assign out_data = mem[rd_ptr];

   // Storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // Pointers wrap at depth, which need not be a power of two
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + ptr_w'(1);
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + ptr_w'(1);
         end
         // Simultaneous push and pop leave the count alone
         if (push && !pop) begin
            count <= count + cnt_w'(1);
         end else if (pop && !push) begin
            count <= count - cnt_w'(1);
         end
      end
   end

endmodule

`default_nettype wire

//--- vlog.f
verilog/axi_bus_pkg.sv
verilog/split_cfg_pkg.sv
verilog/lane_ctrl_if.sv
verilog/sync_fifo.sv
verilog/split_lane.sv
verilog/split_join_ctrl.sv
verilog/axi_split_top.sv
verification/tb_axi_split.sv
